/* Makefile */
# Verilator build and run for the ctrl_fanout testbench
# run from the project root so the case file path resolves

VERILATOR ?= verilator
TOP       ?= tb_ctrl_fanout
FILELIST  ?= ctrl_fanout.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_TEXT ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)/obj
	-$(BUILD_DIR)/obj/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

/* ctrl_fanout.f */
hw/ctrl_fanout_pkg.sv
hw/write_responder.sv
hw/read_responder.sv
hw/read_data_merge.sv
hw/ctrl_fanout_top.sv
verif/ctrl_fanout_properties.sv
verif/tb_ctrl_fanout.sv

/* hw/ctrl_fanout_pkg.sv */
/* bus widths and codes for the four-way AXI4-Lite control fanout
   only OKAY is ever returned, error codes are not defined */
`default_nettype none

package ctrl_fanout_pkg;

    // host control bus geometry
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // one strobe bit per data byte
    localparam int strb_width = data_width / 8;

    // number of virtual-switch register blocks on the far side
    // sizes every per-switch vector in the design
    localparam int num_switches = 4;

    // AXI response field
    localparam int resp_width = 2;

    // the bridge never reports an error
    localparam logic [resp_width-1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

/* hw/ctrl_fanout_top.sv */
/* broadcasts one AXI4-Lite host port to four switch register blocks
   switch bresp, bvalid, rresp and rvalid are not used; the bridge answers itself */
`timescale 1ns/1ps
`default_nettype none

module ctrl_fanout_top
    import ctrl_fanout_pkg::*;
(
    input  wire                               M_AXI_ACLK,
    input  wire                               M_AXI_ARESETN,
    // host side
    input  wire [addr_width-1:0]              M_AXI_AWADDR,
    input  wire                               M_AXI_AWVALID,
    output wire                               M_AXI_AWREADY,
    input  wire [data_width-1:0]              M_AXI_WDATA,
    input  wire [strb_width-1:0]              M_AXI_WSTRB,
    input  wire                               M_AXI_WVALID,
    output wire                               M_AXI_WREADY,
    output wire [resp_width-1:0]              M_AXI_BRESP,
    output wire                               M_AXI_BVALID,
    input  wire                               M_AXI_BREADY,
    input  wire [addr_width-1:0]              M_AXI_ARADDR,
    input  wire                               M_AXI_ARVALID,
    output wire                               M_AXI_ARREADY,
    output wire [data_width-1:0]              M_AXI_RDATA,
    output wire [resp_width-1:0]              M_AXI_RRESP,
    output wire                               M_AXI_RVALID,
    input  wire                               M_AXI_RREADY,
    // switch side, one field per switch, switch 0 in the low bits
    output wire [num_switches*addr_width-1:0] S_AXI_AWADDR,
    output wire [num_switches-1:0]            S_AXI_AWVALID,
    input  wire [num_switches-1:0]            S_AXI_AWREADY,
    output wire [num_switches*data_width-1:0] S_AXI_WDATA,
    output wire [num_switches*strb_width-1:0] S_AXI_WSTRB,
    output wire [num_switches-1:0]            S_AXI_WVALID,
    input  wire [num_switches-1:0]            S_AXI_WREADY,
    output wire [num_switches-1:0]            S_AXI_BREADY,
    output wire [num_switches*addr_width-1:0] S_AXI_ARADDR,
    output wire [num_switches-1:0]            S_AXI_ARVALID,
    input  wire [num_switches-1:0]            S_AXI_ARREADY,
    input  wire [num_switches*data_width-1:0] S_AXI_RDATA,
    output wire [num_switches-1:0]            S_AXI_RREADY
);

    // write channels, same value to every switch
    assign S_AXI_AWADDR  = {num_switches{M_AXI_AWADDR}};
    assign S_AXI_AWVALID = {num_switches{M_AXI_AWVALID}};
    assign S_AXI_WDATA   = {num_switches{M_AXI_WDATA}};
    assign S_AXI_WSTRB   = {num_switches{M_AXI_WSTRB}};
    assign S_AXI_WVALID  = {num_switches{M_AXI_WVALID}};
    assign S_AXI_BREADY  = {num_switches{M_AXI_BREADY}};

    // read request, also broadcast
    // every switch sees the read, only switch 0 gates it
    assign S_AXI_ARADDR  = {num_switches{M_AXI_ARADDR}};
    assign S_AXI_ARVALID = {num_switches{M_AXI_ARVALID}};
    assign S_AXI_RREADY  = {num_switches{M_AXI_RREADY}};

    // write address, data and response toward the host
    write_responder u_write_responder (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .awvalid       (M_AXI_AWVALID),
        .wvalid        (M_AXI_WVALID),
        .bready        (M_AXI_BREADY),
        .sw_awready    (S_AXI_AWREADY),
        .sw_wready     (S_AXI_WREADY),
        .awready       (M_AXI_AWREADY),
        .wready        (M_AXI_WREADY),
        .bvalid        (M_AXI_BVALID),
        .bresp         (M_AXI_BRESP)
    );

    // read address and read valid toward the host
    read_responder u_read_responder (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .arvalid       (M_AXI_ARVALID),
        .rready        (M_AXI_RREADY),
        .sw0_arready   (S_AXI_ARREADY[0]),
        .arready       (M_AXI_ARREADY),
        .rvalid        (M_AXI_RVALID),
        .rresp         (M_AXI_RRESP)
    );

    // read data, merged from all switches every cycle
    read_data_merge u_read_data_merge (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .sw_rdata      (S_AXI_RDATA),
        .rdata         (M_AXI_RDATA)
    );

endmodule

`default_nettype wire

/* hw/read_data_merge.sv */
/* picks the non-zero read word of the highest-numbered switch every cycle
   a switch that returns zero cannot be told apart from an idle one */
`timescale 1ns/1ps
`default_nettype none

module read_data_merge
    import ctrl_fanout_pkg::*;
(
    input  wire                               M_AXI_ACLK,
    input  wire                               M_AXI_ARESETN,
    input  wire [num_switches*data_width-1:0] sw_rdata,
    output logic [data_width-1:0]             rdata
);

    // combinational winner before the output register
    logic [data_width-1:0] pick;

    // walk upward so a later non-zero word overrides
    // the highest index wins, zero when nobody answers
    always_comb
    begin
        pick = '0;
        for (int i = 0; i < num_switches; i++)
        begin
            if (sw_rdata[i*data_width +: data_width] != '0)
                pick = sw_rdata[i*data_width +: data_width];
        end
    end

    // free-running, not tied to the read handshake
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            rdata <= '0;
        else
            rdata <= pick;
    end

endmodule

`default_nettype wire

/* hw/read_responder.sv */
/* answers AXI4-Lite reads for the fanout; only switch 0 readiness starts a read
   one read outstanding at a time, response is always OKAY */
`timescale 1ns/1ps
`default_nettype none

module read_responder
    import ctrl_fanout_pkg::*;
(
    input  wire                   M_AXI_ACLK,
    input  wire                   M_AXI_ARESETN,
    input  wire                   arvalid,
    input  wire                   rready,
    input  wire                   sw0_arready,
    output logic                  arready,
    output logic                  rvalid,
    output logic [resp_width-1:0] rresp
);

    // address handshake on this edge
    logic read_fire;

    assign read_fire = arready && arvalid;

    // read address ready
    // single-cycle pulse, gated by switch 0 alone
    // switches 1 to 3 only follow along on the broadcast
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            arready <= 1'b0;
        else
            arready <= !arready && arvalid && sw0_arready;
    end

    // read valid, one cycle after the address handshake
    // data itself comes from the merge register
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            rvalid <= 1'b0;
            rresp  <= resp_okay;
        end
        else if (read_fire && !rvalid)
        begin
            rvalid <= 1'b1;
            rresp  <= resp_okay;
        end
        else if (rvalid && rready)
        begin
            // host has taken the data
            rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/write_responder.sv */
/* answers AXI4-Lite writes for the fanout; one write outstanding at a time
   if the address and data ready pulses land in different cycles no response follows */
`timescale 1ns/1ps
`default_nettype none

module write_responder
    import ctrl_fanout_pkg::*;
(
    input  wire                    M_AXI_ACLK,
    input  wire                    M_AXI_ARESETN,
    input  wire                    awvalid,
    input  wire                    wvalid,
    input  wire                    bready,
    input  wire [num_switches-1:0] sw_awready,
    input  wire [num_switches-1:0] sw_wready,
    output logic                   awready,
    output logic                   wready,
    output logic                   bvalid,
    output logic [resp_width-1:0]  bresp
);

    // one ready switch is enough to take the channel
    logic any_awready;
    logic any_wready;
    // both channels present a request to the bridge
    logic write_req;
    // address and data both handshake on this edge
    logic write_fire;

    assign any_awready = |sw_awready;
    assign any_wready  = |sw_wready;
    assign write_req   = awvalid && wvalid;
    assign write_fire  = awready && awvalid && wready && wvalid;

    // address ready, a single-cycle pulse
    // waits for both address and data valid from the host
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            awready <= 1'b0;
        else
            awready <= !awready && write_req && any_awready;
    end

    // data ready, same rule against the switch data readiness
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
            wready <= 1'b0;
        else
            wready <= !wready && write_req && any_wready;
    end

    // write response
    // raised on the joint handshake, held until the host takes it
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            bvalid <= 1'b0;
            bresp  <= resp_okay;
        end
        else if (write_fire && !bvalid)
        begin
            bvalid <= 1'b1;
            // switch responses are not looked at
            bresp  <= resp_okay;
        end
        else if (bvalid && bready)
        begin
            bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verif/ctrl_fanout_cases.txt */
# op addr data awmask wmask armask rd0 rd1 rd2 rd3 hs exp_rdata, all hex
# op 0 reset check, 1 write, 2 read, 3 merge; hs 1 handshake expected, 0 stall
0 00000000 00000000 0 0 0 00000000 00000000 00000000 00000000 0 00000000
1 00001000 deadbeef f f 0 00000000 00000000 00000000 00000000 1 00000000
1 00001004 12345678 1 1 0 00000000 00000000 00000000 00000000 1 00000000
1 00002008 a5a55a5a 8 2 0 00000000 00000000 00000000 00000000 1 00000000
1 0000200c 0badf00d 4 8 0 00000000 00000000 00000000 00000000 1 00000000
1 00003000 ffffffff 0 0 0 00000000 00000000 00000000 00000000 0 00000000
1 00003004 00000001 0 4 0 00000000 00000000 00000000 00000000 0 00000000
1 00003008 00000002 2 0 0 00000000 00000000 00000000 00000000 0 00000000
2 00004000 00000000 0 0 1 11111111 00000000 33333333 00000000 1 33333333
2 00004004 00000000 0 0 f 11111111 22222222 33333333 44444444 1 44444444
2 00004008 00000000 0 0 e 55555555 66666666 00000000 00000000 0 00000000
2 0000400c 00000000 0 0 0 00000000 00000000 00000000 00000000 0 00000000
2 00004010 00000000 0 0 1 00000000 00000000 00000000 00000000 1 00000000
3 00000000 00000000 0 0 0 00000000 00000000 00000000 00000000 0 00000000
3 00000000 00000000 0 0 0 a5a5a5a5 00000000 00000000 00000000 0 a5a5a5a5
3 00000000 00000000 0 0 0 00000001 00000002 00000003 00000004 0 00000004
3 00000000 00000000 0 0 0 00000001 00000002 00000000 00000000 0 00000002
3 00000000 00000000 0 0 0 00000000 00000000 00000000 80000000 0 80000000
3 00000000 00000000 0 0 0 ffffffff 00000001 00000000 00000000 0 00000001
0 00000000 00000000 0 0 0 00000000 00000000 00000000 00000000 0 00000000
1 00005000 cafef00d 3 c 0 00000000 00000000 00000000 00000000 1 00000000

/* verif/ctrl_fanout_properties.sv */
/* host-side handshake rules of the fanout, bound into the top level
   checked only while out of reset */
`timescale 1ns/1ps
`default_nettype none

module ctrl_fanout_properties
    import ctrl_fanout_pkg::*;
(
    input wire                  M_AXI_ACLK,
    input wire                  M_AXI_ARESETN,
    input wire                  M_AXI_AWREADY,
    input wire                  M_AXI_ARREADY,
    input wire                  M_AXI_BVALID,
    input wire                  M_AXI_BREADY,
    input wire [resp_width-1:0] M_AXI_BRESP,
    input wire                  M_AXI_RVALID,
    input wire                  M_AXI_RREADY,
    input wire [resp_width-1:0] M_AXI_RRESP
);

    // ready outputs are single-cycle pulses
    awready_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_AWREADY |=> !M_AXI_AWREADY)
    else $error("awready high for two cycles in a row");

    arready_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_ARREADY |=> !M_AXI_ARREADY)
    else $error("arready high for two cycles in a row");

    // responses wait for the host
    bvalid_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_BVALID && !M_AXI_BREADY |=> M_AXI_BVALID)
    else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_RVALID && !M_AXI_RREADY |=> M_AXI_RVALID)
    else $error("rvalid dropped before rready");

    resp_always_okay: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_BRESP == resp_okay && M_AXI_RRESP == resp_okay)
    else $error("response code other than OKAY");

endmodule

bind ctrl_fanout_top ctrl_fanout_properties u_properties (.*);

`default_nettype wire

/* verif/tb_ctrl_fanout.sv */
/* reads verif/ctrl_fanout_cases.txt relative to the project root
   one transaction at a time, bready and rready held off for 0 to 7 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_fanout
    import ctrl_fanout_pkg::*;
();

    localparam int clk_period = 10;
    localparam int reset_cycles = 10;
    localparam string cases_file = "verif/ctrl_fanout_cases.txt";

    logic M_AXI_ACLK;
    logic M_AXI_ARESETN;
    // host side
    logic [addr_width-1:0] awaddr;
    logic awvalid;
    wire awready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic wvalid;
    wire wready;
    wire [resp_width-1:0] bresp;
    wire bvalid;
    logic bready;
    logic [addr_width-1:0] araddr;
    logic arvalid;
    wire arready;
    wire [data_width-1:0] rdata;
    wire [resp_width-1:0] rresp;
    wire rvalid;
    logic rready;
    // switch side
    wire [num_switches*addr_width-1:0] sw_awaddr;
    wire [num_switches-1:0] sw_awvalid;
    logic [num_switches-1:0] sw_awready;
    wire [num_switches*data_width-1:0] sw_wdata;
    wire [num_switches*strb_width-1:0] sw_wstrb;
    wire [num_switches-1:0] sw_wvalid;
    logic [num_switches-1:0] sw_wready;
    wire [num_switches-1:0] sw_bready;
    wire [num_switches*addr_width-1:0] sw_araddr;
    wire [num_switches-1:0] sw_arvalid;
    logic [num_switches-1:0] sw_arready;
    logic [num_switches*data_width-1:0] sw_rdata;
    wire [num_switches-1:0] sw_rready;

    string case_lines[$];
    bit cases_ready = 1'b0;
    int check_count = 0;
    int mismatch_count = 0;
    int other_count = 0;
    logic [15:0] lfsr_state = 16'd5780;

    ctrl_fanout_top u_dut (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .M_AXI_AWADDR  (awaddr),
        .M_AXI_AWVALID (awvalid),
        .M_AXI_AWREADY (awready),
        .M_AXI_WDATA   (wdata),
        .M_AXI_WSTRB   (wstrb),
        .M_AXI_WVALID  (wvalid),
        .M_AXI_WREADY  (wready),
        .M_AXI_BRESP   (bresp),
        .M_AXI_BVALID  (bvalid),
        .M_AXI_BREADY  (bready),
        .M_AXI_ARADDR  (araddr),
        .M_AXI_ARVALID (arvalid),
        .M_AXI_ARREADY (arready),
        .M_AXI_RDATA   (rdata),
        .M_AXI_RRESP   (rresp),
        .M_AXI_RVALID  (rvalid),
        .M_AXI_RREADY  (rready),
        .S_AXI_AWADDR  (sw_awaddr),
        .S_AXI_AWVALID (sw_awvalid),
        .S_AXI_AWREADY (sw_awready),
        .S_AXI_WDATA   (sw_wdata),
        .S_AXI_WSTRB   (sw_wstrb),
        .S_AXI_WVALID  (sw_wvalid),
        .S_AXI_WREADY  (sw_wready),
        .S_AXI_BREADY  (sw_bready),
        .S_AXI_ARADDR  (sw_araddr),
        .S_AXI_ARVALID (sw_arvalid),
        .S_AXI_ARREADY (sw_arready),
        .S_AXI_RDATA   (sw_rdata),
        .S_AXI_RREADY  (sw_rready)
    );

    initial
    begin
        M_AXI_ACLK = 1'b0;
        forever #(clk_period / 2) M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // three bits, one step each
    task automatic random_hold(output int cycles);
        cycles = 0;
        for (int b = 0; b < 3; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            cycles = (cycles << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        other_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic drive_idle;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        sw_awready = '0;
        sw_wready = '0;
        sw_arready = '0;
        sw_rdata = '0;
    endtask

    // every switch sees exactly the host value
    task automatic check_broadcast;
        for (int i = 0; i < num_switches; i++)
        begin
            compare($sformatf("S_AXI_AWADDR[%0d]", i), awaddr,
                    sw_awaddr[i*addr_width +: addr_width]);
            compare($sformatf("S_AXI_WDATA[%0d]", i), wdata,
                    sw_wdata[i*data_width +: data_width]);
            compare($sformatf("S_AXI_WSTRB[%0d]", i), 32'(wstrb),
                    32'(sw_wstrb[i*strb_width +: strb_width]));
            compare($sformatf("S_AXI_ARADDR[%0d]", i), araddr,
                    sw_araddr[i*addr_width +: addr_width]);
            compare($sformatf("S_AXI_AWVALID[%0d]", i), 32'(awvalid), 32'(sw_awvalid[i]));
            compare($sformatf("S_AXI_WVALID[%0d]", i), 32'(wvalid), 32'(sw_wvalid[i]));
            compare($sformatf("S_AXI_ARVALID[%0d]", i), 32'(arvalid), 32'(sw_arvalid[i]));
            compare($sformatf("S_AXI_BREADY[%0d]", i), 32'(bready), 32'(sw_bready[i]));
            compare($sformatf("S_AXI_RREADY[%0d]", i), 32'(rready), 32'(sw_rready[i]));
        end
    endtask

    task automatic finish_case;
        @(negedge M_AXI_ACLK);
        drive_idle();
        repeat (2) @(negedge M_AXI_ACLK);
    endtask

    // handshake outputs low and read data cleared
    task automatic check_reset_outputs;
        compare("M_AXI_AWREADY", 32'd0, 32'(awready));
        compare("M_AXI_WREADY", 32'd0, 32'(wready));
        compare("M_AXI_BVALID", 32'd0, 32'(bvalid));
        compare("M_AXI_ARREADY", 32'd0, 32'(arready));
        compare("M_AXI_RVALID", 32'd0, 32'(rvalid));
        compare("M_AXI_RDATA", 32'd0, rdata);
    endtask

    task automatic apply_reset;
        @(negedge M_AXI_ACLK);
        M_AXI_ARESETN = 1'b0;
        drive_idle();
        // live requests, ready switches and non-zero read data all held off by reset
        awvalid = 1'b1;
        wvalid = 1'b1;
        arvalid = 1'b1;
        sw_awready = '1;
        sw_wready = '1;
        sw_arready = '1;
        sw_rdata = '1;
        repeat (reset_cycles) @(negedge M_AXI_ACLK);
        check_reset_outputs();
        drive_idle();
        M_AXI_ARESETN = 1'b1;
        @(negedge M_AXI_ACLK);
        check_reset_outputs();
    endtask

    task automatic run_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [num_switches-1:0] aw_mask,
                             input logic [num_switches-1:0] w_mask, input logic hs);
        int waited;
        int hold;
        @(negedge M_AXI_ACLK);
        awaddr = addr;
        wdata = data;
        wstrb = '1;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b0;
        sw_awready = aw_mask;
        sw_wready = w_mask;
        #1;
        check_broadcast();
        if (hs)
        begin
            waited = 0;
            do
            begin
                @(negedge M_AXI_ACLK);
                waited++;
            end while (!awready && !wready && waited < 20);
            if (!awready && !wready)
                report_error("write address and data were never accepted");
            // both readies pulse together, response follows one cycle later
            compare("M_AXI_AWREADY", 32'd1, 32'(awready));
            compare("M_AXI_WREADY", 32'd1, 32'(wready));
            compare("M_AXI_BVALID", 32'd0, 32'(bvalid));
            @(negedge M_AXI_ACLK);
            awvalid = 1'b0;
            wvalid = 1'b0;
            compare("M_AXI_AWREADY", 32'd0, 32'(awready));
            compare("M_AXI_WREADY", 32'd0, 32'(wready));
            compare("M_AXI_BVALID", 32'd1, 32'(bvalid));
            compare("M_AXI_BRESP", 32'(resp_okay), 32'(bresp));
            random_hold(hold);
            repeat (hold)
            begin
                @(negedge M_AXI_ACLK);
                compare("M_AXI_BVALID", 32'd1, 32'(bvalid));
            end
            bready = 1'b1;
            #1;
            check_broadcast();
            @(negedge M_AXI_ACLK);
            compare("M_AXI_BVALID", 32'd0, 32'(bvalid));
        end
        else
        begin
            // a channel with no ready switch never pulses
            repeat (20)
            begin
                @(negedge M_AXI_ACLK);
                if (aw_mask == '0)
                    compare("M_AXI_AWREADY", 32'd0, 32'(awready));
                if (w_mask == '0)
                    compare("M_AXI_WREADY", 32'd0, 32'(wready));
                compare("M_AXI_BVALID", 32'd0, 32'(bvalid));
            end
        end
        finish_case();
    endtask

    task automatic run_read(input logic [31:0] addr, input logic [num_switches-1:0] ar_mask,
                            input logic [num_switches*data_width-1:0] words,
                            input logic hs, input logic [31:0] exp_rdata);
        int waited;
        int hold;
        @(negedge M_AXI_ACLK);
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b0;
        sw_arready = ar_mask;
        sw_rdata = words;
        #1;
        check_broadcast();
        if (hs)
        begin
            waited = 0;
            do
            begin
                @(negedge M_AXI_ACLK);
                waited++;
            end while (!arready && waited < 20);
            if (!arready)
                report_error("read address was never accepted with switch 0 ready");
            compare("M_AXI_RVALID", 32'd0, 32'(rvalid));
            @(negedge M_AXI_ACLK);
            arvalid = 1'b0;
            compare("M_AXI_ARREADY", 32'd0, 32'(arready));
            compare("M_AXI_RVALID", 32'd1, 32'(rvalid));
            compare("M_AXI_RRESP", 32'(resp_okay), 32'(rresp));
            compare("M_AXI_RDATA", exp_rdata, rdata);
            random_hold(hold);
            repeat (hold)
            begin
                @(negedge M_AXI_ACLK);
                compare("M_AXI_RVALID", 32'd1, 32'(rvalid));
            end
            rready = 1'b1;
            #1;
            check_broadcast();
            @(negedge M_AXI_ACLK);
            compare("M_AXI_RVALID", 32'd0, 32'(rvalid));
        end
        else
        begin
            repeat (20)
            begin
                @(negedge M_AXI_ACLK);
                compare("M_AXI_ARREADY", 32'd0, 32'(arready));
                compare("M_AXI_RVALID", 32'd0, 32'(rvalid));
            end
        end
        finish_case();
    endtask

    // words held for two edges before rdata is looked at
    task automatic run_merge(input logic [num_switches*data_width-1:0] words,
                             input logic [31:0] exp_rdata);
        @(negedge M_AXI_ACLK);
        sw_rdata = words;
        repeat (2) @(negedge M_AXI_ACLK);
        compare("M_AXI_RDATA", exp_rdata, rdata);
        finish_case();
    endtask

    task automatic load_cases;
        int fd;
        int status;
        string line;
        fd = $fopen(cases_file, "r");
        if (fd == 0)
        begin
            report_error({"cannot open case file ", cases_file});
            return;
        end
        while (!$feof(fd))
        begin
            status = $fgets(line, fd);
            // comment and blank lines carry no case
            if (status > 0 && line.len() > 1 && line[0] != "#")
                case_lines.push_back(line);
        end
        $fclose(fd);
    endtask

    initial
    begin
        longint limit_ns;
        wait (cases_ready);
        limit_ns = longint'(reset_cycles + case_lines.size() * 40) * clk_period;
        #(limit_ns);
        $display("watchdog: the run did not finish within %0d ns and timed out", limit_ns);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        int n;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] awm;
        logic [31:0] wm;
        logic [31:0] arm;
        logic [31:0] rd0;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] rd3;
        logic [31:0] hs;
        logic [31:0] exp_rd;
        M_AXI_ARESETN = 1'b0;
        drive_idle();
        load_cases();
        cases_ready = 1'b1;
        apply_reset();
        for (int k = 0; k < case_lines.size(); k++)
        begin
            n = $sscanf(case_lines[k], "%h %h %h %h %h %h %h %h %h %h %h %h", op, addr,
                        data, awm, wm, arm, rd0, rd1, rd2, rd3, hs, exp_rd);
            if (n != 12)
                report_error($sformatf("case line %0d could not be parsed", k));
            else
            begin
                case (op)
                    32'd0: apply_reset();
                    32'd1: run_write(addr, data, awm[num_switches-1:0],
                                     wm[num_switches-1:0], hs[0]);
                    32'd2: run_read(addr, arm[num_switches-1:0], {rd3, rd2, rd1, rd0},
                                    hs[0], exp_rd);
                    32'd3: run_merge({rd3, rd2, rd1, rd0}, exp_rd);
                    default: report_error($sformatf("case %0d has unknown operation %0h",
                                                    k, op));
                endcase
            end
        end
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
